//--- Makefile
# Verilator build and run for the stream switch testbench

VERILATOR ?= verilator
TOP       ?= xbar_switch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES   := $(shell cat $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/xbar_cfg_pkg.sv
`default_nettype none

package xbar_cfg_pkg;

    //////////////////////////////////////////////////
    // Switch geometry
    //////////////////////////////////////////////////

    // Inputs and outputs, same count on both sides
    localparam int NUM_PORTS  = 4;
    localparam int PORT_W     = 2;

    // Beat payload
    localparam int DATA_W     = 64;
    localparam int KEEP_W     = DATA_W / 8;

    //////////////////////////////////////////////////
    // Ingress buffering
    //////////////////////////////////////////////////

    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

endpackage

`default_nettype wire

//--- source/xbar_ingress_fifo.sv
`default_nettype none

module xbar_ingress_fifo
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  wire logic            i_clk,
    input  wire logic            i_rst,

    // Input stream
    input  wire logic            i_valid,
    input  wire ingress_beat_t   i_beat,
    output logic                 o_ready,

    // Toward the output arbiters
    output port_mask_t           o_req,
    output stream_beat_t         o_head,
    input  wire logic            i_pop
);

    ingress_beat_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                push;
    logic                pop;
    logic                empty;
    ingress_beat_t       head;
    logic                head_first;
    port_id_t            held_dest;
    port_id_t            head_dest;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign o_ready = (count != CNT_W'(FIFO_DEPTH));
    assign push    = i_valid && o_ready;
    assign pop     = i_pop && !empty;
    assign head    = mem[rd_ptr];

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_beat;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Packet tracking
    //////////////////////////////////////////////////

    // Beat after a last is the start of the next packet
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            head_first <= 1'b1;
            held_dest  <= '0;
        end else if (pop) begin
            head_first <= head.beat.last;
            if (head_first) begin
                held_dest <= head.dest;
            end
        end
    end

    // Later beats ignore their own dest field
    assign head_dest = head_first ? head.dest : held_dest;

    assign o_req  = empty ? '0 : (port_mask_t'(1) << head_dest);
    assign o_head = head.beat;

endmodule

`default_nettype wire

//--- source/xbar_output_arbiter.sv
`default_nettype none

module xbar_output_arbiter
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  wire logic            i_clk,
    input  wire logic            i_rst,

    // Request column for this output, bit i from input i
    input  wire port_mask_t      i_req,
    input  wire stream_beat_t    i_heads [NUM_PORTS],
    output port_mask_t           o_grant,

    // Output stream
    output logic                 o_tx_valid,
    output stream_beat_t         o_tx_beat,
    input  wire logic            i_tx_ready
);

    arb_state_e     state;
    port_id_t       last_win;
    port_id_t       next_win;
    port_id_t       cand;
    logic           found;
    logic           locked;
    logic           release_pkt;

    //////////////////////////////////////////////////
    // Round-robin pick
    //////////////////////////////////////////////////

    // Search starts one past the last winner
    always_comb begin
        next_win = last_win;
        cand     = last_win;
        found    = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            cand = port_id_t'((int'(last_win) + k) % NUM_PORTS);
            if (!found && i_req[cand]) begin
                next_win = cand;
                found    = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Lock FSM
    //////////////////////////////////////////////////

    assign locked      = (state == ARB_LOCKED);
    assign release_pkt = o_tx_valid && i_tx_ready && o_tx_beat.last;

    // Winner is kept until its last beat leaves
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state    <= ARB_IDLE;
            last_win <= port_id_t'(NUM_PORTS - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        state    <= ARB_LOCKED;
                        last_win <= next_win;
                    end
                end
                ARB_LOCKED: begin
                    if (release_pkt) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Beat multiplexer
    //////////////////////////////////////////////////

    assign o_grant = locked ? (port_mask_t'(1) << last_win) : '0;

    // Winner's FIFO may run dry mid-packet, valid follows its request
    assign o_tx_valid = locked && i_req[last_win];
    assign o_tx_beat  = i_heads[last_win];

endmodule

`default_nettype wire

//--- source/xbar_switch.sv
`default_nettype none

module xbar_switch
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  wire logic                    i_clk,
    input  wire logic                    i_rst,

    // Input ports
    input  wire logic [NUM_PORTS-1:0]    i_rx_valid,
    input  wire ingress_beat_t           i_rx_beat [NUM_PORTS],
    output wire logic [NUM_PORTS-1:0]    o_rx_ready,

    // Output ports
    output wire logic [NUM_PORTS-1:0]    o_tx_valid,
    output wire stream_beat_t            o_tx_beat [NUM_PORTS],
    input  wire logic [NUM_PORTS-1:0]    i_tx_ready
);

    wire port_mask_t        in_req    [NUM_PORTS];
    wire port_mask_t        out_grant [NUM_PORTS];
    wire stream_beat_t      heads     [NUM_PORTS];
    port_mask_t             out_req   [NUM_PORTS];
    port_mask_t             in_grant  [NUM_PORTS];
    logic [NUM_PORTS-1:0]   pop;

    //////////////////////////////////////////////////
    // Request/grant transposition
    //////////////////////////////////////////////////

    // in_* rows are per input, out_* rows per output
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int j = 0; j < NUM_PORTS; j++) begin
                out_req[j][i]  = in_req[i][j];
                in_grant[i][j] = out_grant[j][i];
            end
            pop[i] = |(in_grant[i] & in_req[i] & i_tx_ready);
        end
    end

    for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_ingress
        xbar_ingress_fifo u_ingress (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_valid (i_rx_valid[g]),
            .i_beat  (i_rx_beat[g]),
            .o_ready (o_rx_ready[g]),
            .o_req   (in_req[g]),
            .o_head  (heads[g]),
            .i_pop   (pop[g])
        );
    end

    for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_output
        xbar_output_arbiter u_arbiter (
            .i_clk      (i_clk),
            .i_rst      (i_rst),
            .i_req      (out_req[g]),
            .i_heads    (heads),
            .o_grant    (out_grant[g]),
            .o_tx_valid (o_tx_valid[g]),
            .o_tx_beat  (o_tx_beat[g]),
            .i_tx_ready (i_tx_ready[g])
        );
    end

endmodule

`default_nettype wire

//--- source/xbar_types_pkg.sv
`default_nettype none

package xbar_types_pkg;

    import xbar_cfg_pkg::*;

    typedef logic [PORT_W-1:0]    port_id_t;

    // One bit per port, bit i belongs to port i
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // Beat as seen on an output, 74 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              user;
        logic              last;
    } stream_beat_t;

    // Input beat, dest only counts on the first beat of a packet
    typedef struct packed {
        stream_beat_t beat;
        port_id_t     dest;
    } ingress_beat_t;

    typedef enum logic {
        ARB_IDLE   = 1'b0,
        ARB_LOCKED = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire

//--- src.f
source/xbar_cfg_pkg.sv
source/xbar_types_pkg.sv
source/xbar_ingress_fifo.sv
source/xbar_output_arbiter.sv
source/xbar_switch.sv
tests/xbar_switch_props.sv
tests/xbar_switch_tb.sv

//--- tests/xbar_switch_props.sv
`default_nettype none

module xbar_switch_props
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
(
    input  wire logic            i_clk,
    input  wire logic            i_rst,
    input  wire port_mask_t      i_grant,
    input  wire logic            i_tx_valid,
    input  wire stream_beat_t    i_tx_beat,
    input  wire logic            i_tx_ready,
    input  wire arb_state_e      i_state
);

    timeunit 1ns;
    timeprecision 1ps;

    // Stalled beat stays put
    a_hold_stalled: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tx_valid && !i_tx_ready |=> $stable(i_tx_beat))
        else $error("output beat changed while stalled");

    a_grant_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(i_grant))
        else $error("grant mask has more than one bit set");

    // Valid only inside a locked packet
    a_valid_locked: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tx_valid |-> (i_state == ARB_LOCKED))
        else $error("output valid while arbiter idle");

endmodule

bind xbar_output_arbiter xbar_switch_props u_props (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_grant    (o_grant),
    .i_tx_valid (o_tx_valid),
    .i_tx_beat  (o_tx_beat),
    .i_tx_ready (i_tx_ready),
    .i_state    (state)
);

`default_nettype wire

//--- tests/xbar_switch_tb.sv
`default_nettype none

module xbar_switch_tb
    import xbar_cfg_pkg::*;
    import xbar_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES    = 3;
    localparam int RAND_PKTS     = 40;
    localparam int SAT_PKTS      = 12;
    localparam int PHASE_TIMEOUT = 20000;
    localparam int TOTAL_PKTS    = NUM_PORTS * (RAND_PKTS + SAT_PKTS);

    logic                   clk;
    logic                   rst;
    logic [NUM_PORTS-1:0]   rx_valid;
    ingress_beat_t          rx_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0]   rx_ready;
    logic [NUM_PORTS-1:0]   tx_valid;
    stream_beat_t           tx_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0]   tx_ready;

    // Sender state, one slot per input
    logic [31:0]            lfsr_state;
    logic                   sat_mode;
    int                     pkts_left [NUM_PORTS];
    int                     gap_left  [NUM_PORTS];
    int                     pkt_len   [NUM_PORTS];
    int                     beat_no   [NUM_PORTS];
    port_id_t               pkt_dest  [NUM_PORTS];
    logic [NUM_PORTS-1:0]   in_pkt;
    int unsigned            pair_seq  [NUM_PORTS][NUM_PORTS];

    // Reference model, queue index is src * NUM_PORTS + dst
    stream_beat_t           exp_q [NUM_PORTS*NUM_PORTS][$];
    logic [NUM_PORTS-1:0]   out_busy;
    port_id_t               out_src [NUM_PORTS];
    port_id_t               rr_prev;
    int                     rr_count;
    int                     pkts_done;

    xbar_switch u_xbar_switch (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_rx_valid (rx_valid),
        .i_rx_beat  (rx_beat),
        .o_rx_ready (rx_ready),
        .o_tx_valid (tx_valid),
        .o_tx_beat  (tx_beat),
        .i_tx_ready (tx_ready)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Random source and reporting
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        logic        fb;
        v = 0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped after the first failure");
    endtask

    task automatic check_beat(input string what, input stream_beat_t got,
                              input stream_beat_t exp);
        if (got !== exp) begin
            $display("error %0t ns: %s: got data %h keep %h user %b last %b",
                     $time, what, got.data, got.keep, got.user, got.last);
            $display("    expected data %h keep %h user %b last %b",
                     exp.data, exp.keep, exp.user, exp.last);
            stop_with_failure();
        end
    endtask

    task automatic check_port(input string what, input port_id_t got, input port_id_t exp);
        if (got !== exp) begin
            $display("error %0t ns: %s: got port %0d expected %0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_mask(input string what, input port_mask_t got, input port_mask_t exp);
        if (got !== exp) begin
            $display("error %0t ns: %s: got %b expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Data holds src, dst, pair sequence and beat index
    function automatic ingress_beat_t make_beat(input int src);
        ingress_beat_t b;
        b.beat.data = {8'(src), 8'(pkt_dest[src]), 16'(pair_seq[src][pkt_dest[src]]),
                       8'(beat_no[src]), 24'(take_bits(24))};
        b.beat.keep = KEEP_W'(take_bits(KEEP_W));
        b.beat.user = 1'(take_bits(1));
        b.beat.last = (beat_no[src] == pkt_len[src] - 1);
        // Later beats carry junk dest
        b.dest = (beat_no[src] == 0) ? pkt_dest[src] : port_id_t'(take_bits(PORT_W));
        return b;
    endfunction

    task automatic drive_input(input int i, input logic took);
        if (!rx_valid[i] || took) begin
            if (!in_pkt[i] && pkts_left[i] > 0) begin
                if (gap_left[i] > 0) begin
                    gap_left[i]--;
                end else begin
                    pkt_dest[i]  = sat_mode ? port_id_t'(0) : port_id_t'(take_bits(PORT_W));
                    pkt_len[i]   = 1 + int'(take_bits(3) % 6);
                    beat_no[i]   = 0;
                    in_pkt[i]    = 1'b1;
                    pkts_left[i] = pkts_left[i] - 1;
                end
            end
            if (in_pkt[i]) begin
                rx_valid[i] <= 1'b1;
                rx_beat[i]  <= make_beat(i);
            end else begin
                rx_valid[i] <= 1'b0;
            end
        end
    endtask

    task automatic record_input(input int i);
        exp_q[i * NUM_PORTS + int'(pkt_dest[i])].push_back(rx_beat[i].beat);
        beat_no[i] = beat_no[i] + 1;
        if (rx_beat[i].beat.last) begin
            in_pkt[i] = 1'b0;
            pair_seq[i][pkt_dest[i]] = pair_seq[i][pkt_dest[i]] + 1;
            gap_left[i] = sat_mode ? 0 : int'(take_bits(2));
        end
    endtask

    //////////////////////////////////////////////////
    // Output checking
    //////////////////////////////////////////////////

    task automatic check_output(input int j, input stream_beat_t beat);
        port_id_t     src;
        int           idx;
        stream_beat_t exp;
        src = port_id_t'(beat.data[DATA_W-1 -: 8]);
        check_port($sformatf("output %0d dest field", j),
                   port_id_t'(beat.data[DATA_W-9 -: 8]), port_id_t'(j));
        if (out_busy[j]) begin
            check_port($sformatf("output %0d packet lock", j), src, out_src[j]);
        end else begin
            out_busy[j] = 1'b1;
            out_src[j]  = src;
            if (sat_mode && j == 0) begin
                if (rr_count > 0) begin
                    check_port("round-robin order", src,
                               port_id_t'((int'(rr_prev) + 1) % NUM_PORTS));
                end
                rr_prev  = src;
                rr_count = rr_count + 1;
            end
        end
        idx = int'(src) * NUM_PORTS + j;
        if (exp_q[idx].size() == 0) begin
            $display("output %0d sent a beat from input %0d that was never accepted", j, src);
            stop_with_failure();
        end
        exp = exp_q[idx].pop_front();
        check_beat($sformatf("output %0d beat", j), beat, exp);
        if (beat.last) begin
            out_busy[j] = 1'b0;
            pkts_done   = pkts_done + 1;
        end
    endtask

    function automatic int queued_beats();
        int n;
        n = 0;
        for (int k = 0; k < NUM_PORTS * NUM_PORTS; k++) begin
            n += exp_q[k].size();
        end
        return n;
    endfunction

    function automatic logic phase_done();
        int busy;
        busy = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (pkts_left[i] > 0 || in_pkt[i]) begin
                busy++;
            end
        end
        return (busy == 0) && (queued_beats() == 0);
    endfunction

    //////////////////////////////////////////////////
    // Cycle loop
    //////////////////////////////////////////////////

    // Sample at the falling edge, drive at the rising edge
    task automatic step_cycle();
        logic [NUM_PORTS-1:0] took;
        @(negedge clk);
        took = rx_valid & rx_ready;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (took[i]) begin
                record_input(i);
            end
        end
        for (int j = 0; j < NUM_PORTS; j++) begin
            if (tx_valid[j] && tx_ready[j]) begin
                check_output(j, tx_beat[j]);
            end
        end
        @(posedge clk);
        for (int i = 0; i < NUM_PORTS; i++) begin
            drive_input(i, took[i]);
        end
        for (int j = 0; j < NUM_PORTS; j++) begin
            tx_ready[j] <= (take_bits(2) != 0);
        end
    endtask

    task automatic start_phase(input logic saturate, input int pkts);
        sat_mode = saturate;
        rr_count = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            pkts_left[i] = pkts;
            gap_left[i]  = saturate ? 0 : int'(take_bits(2));
        end
    endtask

    task automatic run_phase(input string name);
        int cycles;
        cycles = 0;
        while (!phase_done()) begin
            if (cycles >= PHASE_TIMEOUT) begin
                $display("timeout: %s traffic did not drain in %0d cycles", name, cycles);
                stop_with_failure();
            end
            step_cycle();
            cycles++;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        rx_valid   = '0;
        tx_ready   = '0;
        in_pkt     = '0;
        out_busy   = '0;
        lfsr_state = 32'hd715_f9e9;
        sat_mode   = 1'b0;
        rr_prev    = '0;
        rr_count   = 0;
        pkts_done  = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            rx_beat[i]   = '0;
            pkts_left[i] = 0;
            gap_left[i]  = 0;
            pkt_len[i]   = 1;
            beat_no[i]   = 0;
            pkt_dest[i]  = '0;
            out_src[i]   = '0;
            for (int j = 0; j < NUM_PORTS; j++) begin
                pair_seq[i][j] = 0;
            end
        end

        for (int k = 0; k < RST_CYCLES; k++) begin
            @(negedge clk);
            check_mask("tx_valid in reset", port_mask_t'(tx_valid), '0);
            check_mask("rx_ready in reset", port_mask_t'(rx_ready), '1);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_mask("tx_valid after reset", port_mask_t'(tx_valid), '0);
        check_mask("rx_ready after reset", port_mask_t'(rx_ready), '1);

        start_phase(1'b0, RAND_PKTS);
        run_phase("random");
        // Everyone floods output 0
        start_phase(1'b1, SAT_PKTS);
        run_phase("saturated");

        // Drained switch shows no stray beat and empty FIFOs
        @(negedge clk);
        check_mask("tx_valid after drain", port_mask_t'(tx_valid), '0);
        check_mask("rx_ready after drain", port_mask_t'(rx_ready), '1);

        if (pkts_done == TOTAL_PKTS) begin
            $display("%0d packets delivered", pkts_done);
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("only %0d of %0d packets were delivered", pkts_done, TOTAL_PKTS);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
